// File: verilog/classifier_pkg.sv
`default_nettype none

package classifier_pkg;

	localparam int KEY_WIDTH = 32;
	localparam int SYM_WIDTH = 2;
	localparam int KEY_SYMBOLS = 16;
	localparam int TAG_WIDTH = 12;

	// one rule vector per (position, symbol value) pair
	localparam int TABLE_ENTRIES = KEY_SYMBOLS << SYM_WIDTH;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	typedef logic [KEY_WIDTH-1:0] key_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [SYM_WIDTH-1:0] sym_t;

	// position * 4 + symbol value
	typedef logic [$clog2(TABLE_ENTRIES)-1:0] table_addr_t;

	// entry index lives in bits 7:2
	typedef logic [7:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;

	typedef enum logic [1:0] {
		st_idle,
		st_pass,
		st_drain
	} match_state_t;

endpackage

`default_nettype wire

// File: verilog/header_capture.sv
`timescale 1ns/1ps
`default_nettype none

module header_capture (
	input logic clock,
	input logic reset,
	input logic pkt_valid,
	input logic pkt_sop,
	input logic pkt_eop,
	input classifier_pkg::key_t pkt_data,
	input classifier_pkg::tag_t pkt_tag,
	input logic pkt_ready,
	output classifier_pkg::key_t key,
	output classifier_pkg::tag_t tag,
	output logic key_valid
);

	import classifier_pkg::*;

	logic beat;
	logic [1:0] beat_idx;
	logic [1:0] beat_cnt;
	key_t key_q;
	tag_t tag_q;
	logic key_valid_q;

	assign beat = pkt_valid && pkt_ready;

	// sop always counts as beat 0
	assign beat_idx = pkt_sop ? 2'd0 : beat_cnt;

	// saturates at 2, only beat 1 carries the key
	always_ff @(posedge clock) begin
		if (reset) begin
			beat_cnt <= 2'd0;
		end else if (beat) begin
			if (pkt_eop)
				beat_cnt <= 2'd0;
			else if (beat_idx == 2'd2)
				beat_cnt <= 2'd2;
			else
				beat_cnt <= beat_idx + 2'd1;
		end
	end

	// beat 0 clears, so short packets give a zero key
	always_ff @(posedge clock) begin
		if (beat) begin
			if (beat_idx == 2'd0)
				key_q <= '0;
			else if (beat_idx == 2'd1)
				key_q <= pkt_data;
		end
	end

	always_ff @(posedge clock) begin
		if (beat && pkt_eop)
			tag_q <= pkt_tag;
	end

	always_ff @(posedge clock) begin
		if (reset)
			key_valid_q <= 1'b0;
		else
			key_valid_q <= beat && pkt_eop;
	end

	assign key = key_q;
	assign tag = tag_q;
	assign key_valid = key_valid_q;

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	parameter int AF_LEVEL = 14
) (
	input logic clock,
	input logic reset,
	input logic wr_en,
	input logic [WIDTH-1:0] wr_data,
	input logic rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic empty,
	output logic full,
	output logic almost_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign almost_full = (count >= CNT_W'(AF_LEVEL));

	// show-ahead head
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/rule_table_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rule_table_regs #(
	parameter int RCOUNT = 16,
	parameter int SPLITSIZE = 4,
	localparam int NCOUNT = classifier_pkg::KEY_SYMBOLS / SPLITSIZE
) (
	input logic clock,
	input logic reset,
	input logic awvalid,
	output logic awready,
	input classifier_pkg::axil_addr_t awaddr,
	input logic wvalid,
	output logic wready,
	input classifier_pkg::axil_data_t wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input classifier_pkg::axil_addr_t araddr,
	output logic rvalid,
	input logic rready,
	output classifier_pkg::axil_data_t rdata,
	output logic [1:0] rresp,
	input classifier_pkg::table_addr_t [NCOUNT-1:0] lookup_addr,
	output logic [NCOUNT-1:0][RCOUNT-1:0] lookup_bits
);

	import classifier_pkg::*;

	logic [RCOUNT-1:0] rules [TABLE_ENTRIES];
	logic aw_held;
	axil_addr_t aw_addr_q;
	logic w_held;
	axil_data_t w_data_q;
	logic commit;
	table_addr_t wr_idx;
	table_addr_t rd_idx;

	assign awready = !aw_held;
	assign wready = !w_held;
	assign arready = !rvalid;
	assign bresp = AXI_RESP_OKAY;
	assign rresp = AXI_RESP_OKAY;

	assign wr_idx = aw_addr_q[7:2];
	assign rd_idx = araddr[7:2];

	// both halves held and the response channel free
	assign commit = aw_held && w_held && !bvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int e = 0; e < TABLE_ENTRIES; e++)
				rules[e] <= '0;
		end else if (commit) begin
			rules[wr_idx] <= w_data_q[RCOUNT-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (awvalid && awready)
				aw_held <= 1'b1;
			else if (commit)
				aw_held <= 1'b0;

			if (wvalid && wready)
				w_held <= 1'b1;
			else if (commit)
				w_held <= 1'b0;

			if (commit)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (awvalid && awready)
			aw_addr_q <= awaddr;
		if (wvalid && wready)
			w_data_q <= wdata;
	end

	always_ff @(posedge clock) begin
		if (reset)
			rvalid <= 1'b0;
		else if (arvalid && arready)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// rule vector in the low bits, rest zero
	always_ff @(posedge clock) begin
		if (arvalid && arready)
			rdata <= axil_data_t'(rules[rd_idx]);
	end

	always_comb begin
		for (int i = 0; i < NCOUNT; i++)
			lookup_bits[i] = rules[lookup_addr[i]];
	end

endmodule

`default_nettype wire

// File: verilog/vector_match_engine.sv
`timescale 1ns/1ps
`default_nettype none

module vector_match_engine #(
	parameter int RCOUNT = 16,
	parameter int SPLITSIZE = 4,
	localparam int NCOUNT = classifier_pkg::KEY_SYMBOLS / SPLITSIZE,
	localparam int RIDX_W = (RCOUNT > 1) ? $clog2(RCOUNT) : 1
) (
	input logic clock,
	input logic reset,
	input classifier_pkg::key_t key_in,
	input classifier_pkg::tag_t tag_in,
	input logic key_empty,
	output logic key_pop,
	output classifier_pkg::table_addr_t [NCOUNT-1:0] lookup_addr,
	input logic [NCOUNT-1:0][RCOUNT-1:0] lookup_bits,
	input logic res_full,
	output logic res_wr,
	output classifier_pkg::tag_t res_tag,
	output logic [RIDX_W-1:0] res_rule
);

	import classifier_pkg::*;

	localparam int PASS_W = (SPLITSIZE > 1) ? $clog2(SPLITSIZE) : 1;

	// state tells what bits_q holds
	match_state_t state;
	logic [PASS_W-1:0] pass_idx;
	logic last_pass;
	logic stall;
	logic lookup_go;
	logic [NCOUNT-1:0][RCOUNT-1:0] bits_q;
	logic [RCOUNT-1:0] pass_and;
	logic [RCOUNT-1:0] running;
	logic [RCOUNT-1:0] final_vec;
	tag_t tag_q;

	assign last_pass = (pass_idx == PASS_W'(SPLITSIZE - 1));
	assign stall = (state == st_drain) && res_full;

	// final pass waits for room in the match FIFO
	assign lookup_go = !key_empty && !stall && !(last_pass && res_full);
	assign key_pop = lookup_go && last_pass;

	// interleaved positions, i * SPLITSIZE + pass
	always_comb begin
		int pos;
		sym_t sym;
		for (int i = 0; i < NCOUNT; i++) begin
			pos = i * SPLITSIZE + int'(pass_idx);
			sym = key_in[pos*SYM_WIDTH +: SYM_WIDTH];
			lookup_addr[i] = table_addr_t'((pos << SYM_WIDTH) + int'(sym));
		end
	end

	always_comb begin
		pass_and = '1;
		for (int i = 0; i < NCOUNT; i++)
			pass_and = pass_and & bits_q[i];
	end

	assign final_vec = running & pass_and;

	// lowest set bit wins
	always_comb begin
		res_rule = '0;
		for (int r = RCOUNT - 1; r >= 0; r--) begin
			if (final_vec[r])
				res_rule = RIDX_W'(r);
		end
	end

	assign res_wr = (state == st_drain) && !res_full && (final_vec != '0);
	assign res_tag = tag_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			pass_idx <= '0;
		end else if (!stall) begin
			if (lookup_go) begin
				state <= last_pass ? st_drain : st_pass;
				pass_idx <= last_pass ? '0 : pass_idx + 1'b1;
			end else begin
				state <= st_idle;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= '1;
		end else if (state == st_drain) begin
			if (!res_full)
				running <= '1;
		end else if (state == st_pass) begin
			running <= running & pass_and;
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_go)
			bits_q <= lookup_bits;
		if (key_pop)
			tag_q <= tag_in;
	end

endmodule

`default_nettype wire

// File: verilog/packet_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module packet_classifier #(
	parameter int RCOUNT = 16,
	parameter int SPLITSIZE = 4,
	localparam int RIDX_W = (RCOUNT > 1) ? $clog2(RCOUNT) : 1
) (
	input logic clock,
	input logic reset,
	input logic pkt_valid,
	output logic pkt_ready,
	input classifier_pkg::key_t pkt_data,
	input logic pkt_sop,
	input logic pkt_eop,
	input classifier_pkg::tag_t pkt_tag,
	input logic awvalid,
	output logic awready,
	input classifier_pkg::axil_addr_t awaddr,
	input logic wvalid,
	output logic wready,
	input classifier_pkg::axil_data_t wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input classifier_pkg::axil_addr_t araddr,
	output logic rvalid,
	input logic rready,
	output classifier_pkg::axil_data_t rdata,
	output logic [1:0] rresp,
	output logic match_valid,
	input logic match_ready,
	output classifier_pkg::tag_t match_tag,
	output logic [RIDX_W-1:0] match_rule
);

	import classifier_pkg::*;

	localparam int NCOUNT = KEY_SYMBOLS / SPLITSIZE;
	localparam int KEY_ENTRY_W = TAG_WIDTH + KEY_WIDTH;
	localparam int MATCH_ENTRY_W = TAG_WIDTH + RIDX_W;

	key_t cap_key;
	tag_t cap_tag;
	logic cap_valid;
	logic [KEY_ENTRY_W-1:0] key_entry;
	logic key_empty;
	logic key_afull;
	logic key_pop;
	table_addr_t [NCOUNT-1:0] lookup_addr;
	logic [NCOUNT-1:0][RCOUNT-1:0] lookup_bits;
	logic res_wr;
	logic res_full;
	tag_t res_tag;
	logic [RIDX_W-1:0] res_rule;
	logic [MATCH_ENTRY_W-1:0] match_entry;
	logic match_empty;

	// two slots of slack for the key still in flight
	assign pkt_ready = !key_afull;
	assign match_valid = !match_empty;
	assign {match_tag, match_rule} = match_entry;

	header_capture u_capture (
		.clock(clock),
		.reset(reset),
		.pkt_valid(pkt_valid),
		.pkt_sop(pkt_sop),
		.pkt_eop(pkt_eop),
		.pkt_data(pkt_data),
		.pkt_tag(pkt_tag),
		.pkt_ready(pkt_ready),
		.key(cap_key),
		.tag(cap_tag),
		.key_valid(cap_valid)
	);

	sync_fifo #(
		.WIDTH(KEY_ENTRY_W),
		.DEPTH(16),
		.AF_LEVEL(14)
	) key_fifo (
		.clock(clock),
		.reset(reset),
		.wr_en(cap_valid),
		.wr_data({cap_tag, cap_key}),
		.rd_en(key_pop),
		.rd_data(key_entry),
		.empty(key_empty),
		.full(),
		.almost_full(key_afull)
	);

	rule_table_regs #(
		.RCOUNT(RCOUNT),
		.SPLITSIZE(SPLITSIZE)
	) u_rules (
		.clock(clock),
		.reset(reset),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.lookup_addr(lookup_addr),
		.lookup_bits(lookup_bits)
	);

	vector_match_engine #(
		.RCOUNT(RCOUNT),
		.SPLITSIZE(SPLITSIZE)
	) u_engine (
		.clock(clock),
		.reset(reset),
		.key_in(key_entry[KEY_WIDTH-1:0]),
		.tag_in(key_entry[KEY_ENTRY_W-1:KEY_WIDTH]),
		.key_empty(key_empty),
		.key_pop(key_pop),
		.lookup_addr(lookup_addr),
		.lookup_bits(lookup_bits),
		.res_full(res_full),
		.res_wr(res_wr),
		.res_tag(res_tag),
		.res_rule(res_rule)
	);

	sync_fifo #(
		.WIDTH(MATCH_ENTRY_W),
		.DEPTH(8),
		.AF_LEVEL(8)
	) match_fifo (
		.clock(clock),
		.reset(reset),
		.wr_en(res_wr),
		.wr_data({res_tag, res_rule}),
		.rd_en(match_valid && match_ready),
		.rd_data(match_entry),
		.empty(match_empty),
		.full(res_full),
		.almost_full()
	);

endmodule

`default_nettype wire

// File: dv/packet_classifier_sva.sv
`timescale 1ns/1ps
`default_nettype none

module packet_classifier_sva #(
	parameter int RIDX_W = 4
) (
	input logic clock,
	input logic reset,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic cap_valid,
	input logic key_full,
	input logic res_pending,
	input logic res_full,
	input classifier_pkg::tag_t res_tag,
	input logic [RIDX_W-1:0] res_rule
);

	a_bvalid_hold: assert property (@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// a key still in flight when pkt_ready drops must find room
	a_key_fifo_overflow: assert property (@(posedge clock) disable iff (reset)
		cap_valid |-> !key_full)
		else $error("key FIFO written while full");

	// a result blocked by a full match FIFO waits unchanged
	a_result_held_while_full: assert property (@(posedge clock) disable iff (reset)
		res_pending && res_full |=> res_pending && $stable(res_tag) && $stable(res_rule))
		else $error("match result changed or dropped while the match FIFO was full");

endmodule

bind packet_classifier packet_classifier_sva #(
	.RIDX_W(RIDX_W)
) sva_i (
	.clock(clock),
	.reset(reset),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready),
	.cap_valid(cap_valid),
	.key_full(key_fifo.full),
	.res_pending((u_engine.state == classifier_pkg::st_drain)
		&& (u_engine.final_vec != '0)),
	.res_full(res_full),
	.res_tag(res_tag),
	.res_rule(res_rule)
);

`default_nettype wire

// File: dv/packet_classifier_tb.sv
`timescale 1ns/1ps
`default_nettype none

module packet_classifier_tb;

	import classifier_pkg::*;

	localparam int WAIT_LIMIT = 2000;

	typedef struct packed {
		logic [5:0] idx;
		logic [15:0] vec;
	} wr_row_t;

	typedef struct packed {
		key_t key;
		tag_t tag;
		logic [2:0] beats;
	} pkt_row_t;

	localparam wr_row_t RULE_WRITES [3] = '{
		'{6'd1, 16'h8008}, '{6'd22, 16'h8114}, '{6'd63, 16'hc002}
	};

	// applied after the first traffic to change later results
	localparam wr_row_t RULE_REWRITES [2] = '{
		'{6'd7, 16'h0000}, '{6'd10, 16'h8000}
	};

	localparam pkt_row_t PACKETS [7] = '{
		'{32'hffff_ffff, 12'h001, 3'd2},
		'{32'haaaa_aaaa, 12'h002, 3'd3},
		'{32'h5555_5555, 12'h003, 3'd2},
		'{32'h0000_0000, 12'h004, 3'd1},
		'{32'h1234_5678, 12'h005, 3'd4},
		'{32'hffff_fffd, 12'h006, 3'd2},
		'{32'habcd_ef13, 12'h007, 3'd2}
	};

	localparam pkt_row_t RESENDS [3] = '{
		'{32'hffff_ffff, 12'h101, 3'd2},
		'{32'haaaa_aaaa, 12'h102, 3'd3},
		'{32'h5555_5555, 12'h103, 3'd2}
	};

	logic clock;
	logic reset;
	logic pkt_valid;
	logic pkt_ready;
	key_t pkt_data;
	logic pkt_sop;
	logic pkt_eop;
	tag_t pkt_tag;
	logic awvalid;
	logic awready;
	axil_addr_t awaddr;
	logic wvalid;
	logic wready;
	axil_data_t wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	axil_addr_t araddr;
	logic rvalid;
	logic rready;
	axil_data_t rdata;
	logic [1:0] rresp;
	logic match_valid;
	logic match_ready;
	tag_t match_tag;
	logic [3:0] match_rule;

	logic [15:0] model_table [64];
	logic [15:0] exp_q [$];
	logic [31:0] pkt_seed;
	logic [31:0] ready_seed;
	logic saw_backpressure;

	packet_classifier #(
		.RCOUNT(16),
		.SPLITSIZE(4)
	) uut (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// base table contents, entry 0 stays empty so a zero key never matches
	function automatic logic [15:0] fill_vec(input logic [5:0] a);
		logic [15:0] v;
		if (a == 6'd0)
			return 16'h0000;
		v = 16'h8000 | {2'b00, a, 8'h00};
		if (a[1:0] == 2'd3)
			v = v | 16'h0002;
		if (a[1:0] == 2'd2)
			v = v | 16'h0010;
		return v;
	endfunction

	// returns {hit, tag, rule}
	function automatic logic [16:0] predict(input key_t k, input tag_t t);
		logic [15:0] acc;
		logic [3:0] rule;
		acc = 16'hffff;
		rule = 4'd0;
		for (int p = 0; p < 16; p++)
			acc = acc & model_table[p * 4 + int'(k[p*2 +: 2])];
		for (int r = 15; r >= 0; r--) begin
			if (acc[r])
				rule = 4'(r);
		end
		return {acc != 16'h0000, t, rule};
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %0h actual %0h", name, expected, actual);
			stop_run("value mismatch");
		end
	endtask

	task automatic axi_write(input logic [5:0] idx, input logic [15:0] vec);
		logic aw_done;
		logic w_done;
		int n;
		@(negedge clock);
		awvalid = 1'b1;
		awaddr = {idx, 2'b00};
		wvalid = 1'b1;
		wdata = {16'h0000, vec};
		aw_done = 1'b0;
		w_done = 1'b0;
		n = 0;
		while (!(aw_done && w_done)) begin
			@(posedge clock);
			aw_done = aw_done | (awvalid & awready);
			w_done = w_done | (wvalid & wready);
			@(negedge clock);
			if (aw_done)
				awvalid = 1'b0;
			if (w_done)
				wvalid = 1'b0;
			n++;
			if (n > WAIT_LIMIT)
				stop_run("write address or data was never accepted");
		end
		bready = 1'b1;
		n = 0;
		while (!bvalid) begin
			@(negedge clock);
			n++;
			if (n > WAIT_LIMIT)
				stop_run("no write response arrived");
		end
		check("write response", 32'(2'b00), 32'(bresp));
		@(negedge clock);
		bready = 1'b0;
		model_table[idx] = vec;
	endtask

	task automatic axi_read(input logic [5:0] idx, output logic [31:0] data);
		int n;
		@(negedge clock);
		arvalid = 1'b1;
		araddr = {idx, 2'b00};
		n = 0;
		while (arvalid) begin
			@(posedge clock);
			if (arready) begin
				@(negedge clock);
				arvalid = 1'b0;
			end else begin
				@(negedge clock);
			end
			n++;
			if (n > WAIT_LIMIT)
				stop_run("read address was never accepted");
		end
		rready = 1'b1;
		n = 0;
		while (!rvalid) begin
			@(negedge clock);
			n++;
			if (n > WAIT_LIMIT)
				stop_run("no read data arrived");
		end
		data = rdata;
		check("read response", 32'(2'b00), 32'(rresp));
		@(negedge clock);
		rready = 1'b0;
	endtask

	task automatic write_and_verify(input logic [5:0] idx, input logic [15:0] vec);
		logic [31:0] data;
		axi_write(idx, vec);
		axi_read(idx, data);
		check("table readback", {16'h0000, vec}, data);
	endtask

	task automatic send_packet(input key_t key, input tag_t tag, input logic [2:0] beats,
			input logic gaps);
		logic [16:0] pred;
		logic taken;
		int n;
		pred = predict(key, tag);
		if (pred[16])
			exp_q.push_back(pred[15:0]);
		for (int b = 0; b < int'(beats); b++) begin
			pkt_seed = lcg_next(pkt_seed);
			if (gaps && pkt_seed[30]) begin
				pkt_valid = 1'b0;
				@(negedge clock);
			end
			pkt_valid = 1'b1;
			pkt_sop = (b == 0);
			pkt_eop = (b == int'(beats) - 1);
			pkt_data = (b == 1) ? key : pkt_seed;
			pkt_tag = pkt_eop ? tag : 12'hfff;
			taken = 1'b0;
			n = 0;
			while (!taken) begin
				@(posedge clock);
				taken = pkt_ready;
				@(negedge clock);
				n++;
				if (n > WAIT_LIMIT)
					stop_run("packet beat was never accepted");
			end
		end
		pkt_valid = 1'b0;
		pkt_sop = 1'b0;
		pkt_eop = 1'b0;
	endtask

	task automatic wait_results;
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(negedge clock);
			n++;
			if (n > WAIT_LIMIT)
				stop_run("expected match results did not arrive");
		end
		// room for any extra result to show up
		repeat (30) @(negedge clock);
	endtask

	// sink with random back-pressure
	always @(negedge clock) begin
		if (reset) begin
			match_ready = 1'b0;
		end else begin
			ready_seed = lcg_next(ready_seed);
			match_ready = ready_seed[29];
		end
	end

	always @(posedge clock) begin
		logic [15:0] exp;
		if (!reset) begin
			if (!pkt_ready)
				saw_backpressure = 1'b1;
			if (match_valid && match_ready) begin
				if (exp_q.size() == 0)
					stop_run("a match came out that no packet should produce");
				exp = exp_q.pop_front();
				check("match tag", 32'(exp[15:4]), 32'(match_tag));
				check("match rule", 32'(exp[3:0]), 32'(match_rule));
			end
		end
	end

	initial begin
		logic [31:0] data;
		reset = 1'b1;
		pkt_valid = 1'b0;
		pkt_data = '0;
		pkt_sop = 1'b0;
		pkt_eop = 1'b0;
		pkt_tag = '0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		match_ready = 1'b0;
		pkt_seed = 32'h3e33_387a;
		ready_seed = 32'h3e33_387a ^ 32'h0000_ffff;
		saw_backpressure = 1'b0;
		for (int e = 0; e < 64; e++)
			model_table[e] = 16'h0000;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		check("reset match_valid", 32'(1'b0), 32'(match_valid));
		check("reset pkt_ready", 32'(1'b1), 32'(pkt_ready));
		check("reset awready", 32'(1'b1), 32'(awready));
		check("reset wready", 32'(1'b1), 32'(wready));
		check("reset arready", 32'(1'b1), 32'(arready));
		check("reset bvalid", 32'(1'b0), 32'(bvalid));
		check("reset rvalid", 32'(1'b0), 32'(rvalid));
		axi_read(6'd0, data);
		check("reset entry 0", 32'h0, data);
		axi_read(6'd21, data);
		check("reset entry 21", 32'h0, data);
		axi_read(6'd63, data);
		check("reset entry 63", 32'h0, data);

		for (int e = 0; e < 64; e++)
			write_and_verify(6'(e), fill_vec(6'(e)));
		foreach (RULE_WRITES[i])
			write_and_verify(RULE_WRITES[i].idx, RULE_WRITES[i].vec);

		foreach (PACKETS[i])
			send_packet(PACKETS[i].key, PACKETS[i].tag, PACKETS[i].beats, 1'b1);
		wait_results();

		foreach (RULE_REWRITES[i])
			write_and_verify(RULE_REWRITES[i].idx, RULE_REWRITES[i].vec);
		foreach (RESENDS[i])
			send_packet(RESENDS[i].key, RESENDS[i].tag, RESENDS[i].beats, 1'b1);
		wait_results();

		// back to back burst
		saw_backpressure = 1'b0;
		for (int i = 0; i < 40; i++) begin
			pkt_seed = lcg_next(pkt_seed);
			send_packet(pkt_seed, 12'h200 + 12'(i), 3'd2 + 3'(pkt_seed[20]), 1'b0);
		end
		wait_results();
		check("burst back-pressure seen", 32'(1'b1), 32'(saw_backpressure));
		check("final match_valid", 32'(1'b0), 32'(match_valid));

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: packet_classifier.f
verilog/classifier_pkg.sv
verilog/header_capture.sv
verilog/sync_fifo.sv
verilog/rule_table_regs.sv
verilog/vector_match_engine.sv
verilog/packet_classifier.sv
dv/packet_classifier_sva.sv
dv/packet_classifier_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the packet classifier testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module packet_classifier_tb \
	-f packet_classifier.f \
	-o sim_packet_classifier
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/sim_packet_classifier
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi
exit 0
